//--- Bender.yml
package:
  name: writeback_stage

export_include_dirs:
  - include

sources:
  # Design, package first
  - include_dirs:
      - include
    files:
      - source/writebackPkg.sv
      - source/laneIf.sv
      - source/resultLane.sv
      - source/branchResolver.sv
      - source/writebackStage.sv

  # Testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/clockGen.sv
      - verification/writebackStageTb.sv

//--- flist.f
+incdir+include
source/writebackPkg.sv
source/laneIf.sv
source/resultLane.sv
source/branchResolver.sv
source/writebackStage.sv
verification/clockGen.sv
verification/writebackStageTb.sv

//--- include/writeback_settings.svh
// Width settings for the writeback stage, included by every file that sizes packet fields
`ifndef WRITEBACK_SETTINGS_SVH
`define WRITEBACK_SETTINGS_SVH

// Branch checkpoints, one mask bit per checkpoint
`define CHECKPOINTS             4
`define CHECKPOINTS_LOG         2

// Register file and active list
`define SIZE_PHYSICAL_LOG       6
`define SIZE_ACTIVELIST_LOG     5
`define SIZE_DATA               32

// Issue queue entry freed by the address-generation lane
`define SIZE_ISSUEQ_LOG         5

// Control-transfer queue and addresses
`define SIZE_CTI_LOG            4
`define SIZE_PC                 32

`endif

//--- source/branchResolver.sv
// Branch resolution outputs and the mispredict squash broadcast to every lane
`timescale 1ns/100ps
`include "writeback_settings.svh"

module branchResolver (
        input  logic                        clk,
        input  logic                        reset,

        input  logic                        packetValid_i,
        input  writebackPkg::branchCtrl_t   branchCtrl_i,
        laneIf.consumer                     branch,

        output logic                        squashValid_o,
        output logic [`CHECKPOINTS_LOG-1:0] squashId_o,

        output logic                        ctrlVerified_o,
        output logic                        ctrlMispredict_o,
        output logic                        ctrlConditional_o,
        output logic [`CHECKPOINTS_LOG-1:0] ctrlSmtId_o,
        output logic [`SIZE_PC-1:0]         ctrlTargetAddr_o,
        output logic                        ctrlBrDirection_o,
        output logic [`SIZE_CTI_LOG-1:0]    ctrlCtiQueueIndex_o
);
        import writebackPkg::*;

        branchCtrl_t latchedCtrl;
        logic        verified;
        logic        mispredict;

        // Resolution fields read zero until the first branch arrives
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        latchedCtrl <= '0;
                end
                else if (packetValid_i)
                begin
                        latchedCtrl <= branchCtrl_i;
                end
        end

        assign verified   = branch.latchedValid;
        assign mispredict = verified & branch.packet.flags.wb.mispredict;

        assign squashValid_o = mispredict;
        assign squashId_o    = latchedCtrl.smtId;

        assign ctrlVerified_o      = verified;
        assign ctrlMispredict_o    = mispredict;
        assign ctrlConditional_o   = branch.packet.flags.conditional;
        assign ctrlSmtId_o         = latchedCtrl.smtId;
        assign ctrlTargetAddr_o    = latchedCtrl.targetPc;
        assign ctrlBrDirection_o   = latchedCtrl.direction;
        assign ctrlCtiQueueIndex_o = latchedCtrl.ctiIndex;

endmodule

//--- source/laneIf.sv
// One lane's registered packet and valids, shared between the lane and its consumers
`timescale 1ns/100ps

interface laneIf;
        import writebackPkg::*;

        // Valid as registered, before any squash
        logic        latchedValid;
        lanePacket_t packet;

        logic        wbValid;
        logic        bypassValid;

        modport lane (
                output latchedValid,
                output packet,
                output wbValid,
                output bypassValid
        );

        // Top level and branch resolver
        modport consumer (
                input  latchedValid,
                input  packet,
                input  wbValid,
                input  bypassValid
        );

endinterface

//--- source/resultLane.sv
// Result register for one writeback lane, forms its writeback and bypass valids
`timescale 1ns/100ps
`include "writeback_settings.svh"

module resultLane (
        input  logic                        clk,
        input  logic                        reset,

        input  logic                        packetValid_i,
        input  writebackPkg::lanePacket_t   packet_i,

        // Mispredict broadcast from the branch resolver
        input  logic                        squashValid_i,
        input  logic [`CHECKPOINTS_LOG-1:0] squashId_i,

        laneIf.lane                         lane
);
        import writebackPkg::*;

        logic        latchedValid;
        lanePacket_t latchedPacket;
        logic        squashed;
        logic        wbValid;
        logic        bypassValid;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        latchedValid <= 1'b0;
                end
                else
                begin
                        latchedValid <= packetValid_i;
                end
        end

        // Packet holds its old value on an idle cycle
        always_ff @(posedge clk)
        begin
                if (packetValid_i)
                begin
                        latchedPacket <= packet_i;
                end
        end

        // Result depends on the mispredicted checkpoint
        assign squashed = squashValid_i & latchedPacket.branchMask[squashId_i];

        assign wbValid = latchedValid & ~squashed;

        // Bypass ignores squash, consumers are flushed by the same mispredict
        assign bypassValid = latchedValid & latchedPacket.flags.bypassEnable;

        assign lane.latchedValid = latchedValid;
        assign lane.packet       = latchedPacket;
        assign lane.wbValid      = wbValid;
        assign lane.bypassValid  = bypassValid;

endmodule

//--- source/writebackPkg.sv
// Packet and flag types shared by the writeback stage lanes, resolver and testbench
`include "writeback_settings.svh"

package writebackPkg;

        // Flags reported to the active list with each writeback
        typedef struct packed {
                logic exception;
                logic mispredict;
                logic control;
                logic memory;
        } wbFlags_t;

        // Execution flags as produced by the functional units
        typedef struct packed {
                logic     conditional;
                logic     bypassEnable;
                wbFlags_t wb;
        } execFlags_t;

        // Result common to every lane
        typedef struct packed {
                logic [`CHECKPOINTS-1:0]         branchMask;
                execFlags_t                      flags;
                logic [`SIZE_PHYSICAL_LOG-1:0]   physReg;
                logic [`SIZE_ACTIVELIST_LOG-1:0] alId;
                logic [`SIZE_DATA-1:0]           data;
                logic [`SIZE_ISSUEQ_LOG-1:0]     iqEntry;
        } lanePacket_t;

        // Extra branch fields, smtId is the checkpoint the branch owns
        typedef struct packed {
                logic [`CHECKPOINTS_LOG-1:0] smtId;
                logic [`SIZE_CTI_LOG-1:0]    ctiIndex;
                logic [`SIZE_PC-1:0]         targetPc;
                logic                        direction;
        } branchCtrl_t;

endpackage

//--- source/writebackStage.sv
// Writeback stage top, three result lanes plus branch resolution on plain ports
`timescale 1ns/100ps
`include "writeback_settings.svh"

module writebackStage (
        input  logic                              clk,
        input  logic                              reset,

        input  logic                              aluPacketValid_i,
        input  writebackPkg::lanePacket_t         aluPacket_i,
        input  logic                              branchPacketValid_i,
        input  writebackPkg::lanePacket_t         branchPacket_i,
        input  writebackPkg::branchCtrl_t         branchCtrl_i,
        input  logic                              lsuPacketValid_i,
        input  writebackPkg::lanePacket_t         lsuPacket_i,

        // Simple ALU lane
        output logic                              writebkValidAlu_o,
        output logic [`SIZE_ACTIVELIST_LOG+$bits(writebackPkg::wbFlags_t)-1:0]
                                                  ctrlFuAlu_o,
        output logic                              bypassValidAlu_o,
        output logic [`SIZE_PHYSICAL_LOG-1:0]     bypassPhysRegAlu_o,
        output logic [`SIZE_DATA-1:0]             bypassDataAlu_o,

        // Branch lane
        output logic                              writebkValidBranch_o,
        output logic [`SIZE_ACTIVELIST_LOG+$bits(writebackPkg::wbFlags_t)-1:0]
                                                  ctrlFuBranch_o,
        output logic                              bypassValidBranch_o,
        output logic [`SIZE_PHYSICAL_LOG-1:0]     bypassPhysRegBranch_o,
        output logic [`SIZE_DATA-1:0]             bypassDataBranch_o,

        // Load/store lane
        output logic                              writebkValidLsu_o,
        output logic [`SIZE_ACTIVELIST_LOG+$bits(writebackPkg::wbFlags_t)-1:0]
                                                  ctrlFuLsu_o,
        output logic                              bypassValidLsu_o,
        output logic [`SIZE_PHYSICAL_LOG-1:0]     bypassPhysRegLsu_o,
        output logic [`SIZE_DATA-1:0]             bypassDataLsu_o,

        output logic                              agenIqFreedValid_o,
        output logic [`SIZE_ISSUEQ_LOG-1:0]       agenIqEntry_o,

        output logic                              ctrlVerified_o,
        output logic                              ctrlMispredict_o,
        output logic                              ctrlConditional_o,
        output logic [`CHECKPOINTS_LOG-1:0]       ctrlSmtId_o,
        output logic [`SIZE_PC-1:0]               ctrlTargetAddr_o,
        output logic                              ctrlBrDirection_o,
        output logic [`SIZE_CTI_LOG-1:0]          ctrlCtiQueueIndex_o
);

        laneIf aluIf ();
        laneIf branchIf ();
        laneIf lsuIf ();

        logic                        squashValid;
        logic [`CHECKPOINTS_LOG-1:0] squashId;

        resultLane aluLane (
                .clk           (clk),
                .reset         (reset),
                .packetValid_i (aluPacketValid_i),
                .packet_i      (aluPacket_i),
                .squashValid_i (squashValid),
                .squashId_i    (squashId),
                .lane          (aluIf.lane)
        );

        resultLane branchLane (
                .clk           (clk),
                .reset         (reset),
                .packetValid_i (branchPacketValid_i),
                .packet_i      (branchPacket_i),
                .squashValid_i (squashValid),
                .squashId_i    (squashId),
                .lane          (branchIf.lane)
        );

        resultLane lsuLane (
                .clk           (clk),
                .reset         (reset),
                .packetValid_i (lsuPacketValid_i),
                .packet_i      (lsuPacket_i),
                .squashValid_i (squashValid),
                .squashId_i    (squashId),
                .lane          (lsuIf.lane)
        );

        // Reads the branch lane's latched flags
        branchResolver resolver (
                .clk                 (clk),
                .reset               (reset),
                .packetValid_i       (branchPacketValid_i),
                .branchCtrl_i        (branchCtrl_i),
                .branch              (branchIf.consumer),
                .squashValid_o       (squashValid),
                .squashId_o          (squashId),
                .ctrlVerified_o      (ctrlVerified_o),
                .ctrlMispredict_o    (ctrlMispredict_o),
                .ctrlConditional_o   (ctrlConditional_o),
                .ctrlSmtId_o         (ctrlSmtId_o),
                .ctrlTargetAddr_o    (ctrlTargetAddr_o),
                .ctrlBrDirection_o   (ctrlBrDirection_o),
                .ctrlCtiQueueIndex_o (ctrlCtiQueueIndex_o)
        );

        assign writebkValidAlu_o  = aluIf.wbValid;
        assign ctrlFuAlu_o        = {aluIf.packet.alId, aluIf.packet.flags.wb};
        assign bypassValidAlu_o   = aluIf.bypassValid;
        assign bypassPhysRegAlu_o = aluIf.packet.physReg;
        assign bypassDataAlu_o    = aluIf.packet.data;

        assign writebkValidBranch_o  = branchIf.wbValid;
        assign ctrlFuBranch_o        = {branchIf.packet.alId, branchIf.packet.flags.wb};
        assign bypassValidBranch_o   = branchIf.bypassValid;
        assign bypassPhysRegBranch_o = branchIf.packet.physReg;
        assign bypassDataBranch_o    = branchIf.packet.data;

        assign writebkValidLsu_o  = lsuIf.wbValid;
        assign ctrlFuLsu_o        = {lsuIf.packet.alId, lsuIf.packet.flags.wb};
        assign bypassValidLsu_o   = lsuIf.bypassValid;
        assign bypassPhysRegLsu_o = lsuIf.packet.physReg;
        assign bypassDataLsu_o    = lsuIf.packet.data;

        // AGEN entry is freed even when the result is squashed
        assign agenIqFreedValid_o = lsuIf.latchedValid;
        assign agenIqEntry_o      = lsuIf.packet.iqEntry;

endmodule

//--- verification/clockGen.sv
// Clock and synchronous reset source for the writeback stage testbench
`timescale 1ns/100ps

module clockGen #(
        parameter int halfPeriod  = 2,
        parameter int resetCycles = 10
) (
        output logic clk,
        output logic reset
);
        initial
        begin
                clk = 1'b0;
                forever #halfPeriod clk = ~clk;
        end

        // Released just after an edge, like the other inputs
        initial
        begin
                reset = 1'b1;
                repeat (resetCycles) @(posedge clk);
                #1 reset = 1'b0;
        end

endmodule

//--- verification/writebackStageTb.sv
// Self-checking testbench that drives the writeback stage as the top module of the simulation
`timescale 1ns/100ps
`include "writeback_settings.svh"

module writebackStageTb;
        import writebackPkg::*;

        localparam int ctrlFuWidth = `SIZE_ACTIVELIST_LOG + $bits(wbFlags_t);
        // About 120 cycles of tests plus margin
        localparam int cycleLimit = 400;

        logic clk;
        logic reset;

        logic        aluPacketValid_i;
        lanePacket_t aluPacket_i;
        logic        branchPacketValid_i;
        lanePacket_t branchPacket_i;
        branchCtrl_t branchCtrl_i;
        logic        lsuPacketValid_i;
        lanePacket_t lsuPacket_i;

        logic                          writebkValidAlu_o;
        logic [ctrlFuWidth-1:0]        ctrlFuAlu_o;
        logic                          bypassValidAlu_o;
        logic [`SIZE_PHYSICAL_LOG-1:0] bypassPhysRegAlu_o;
        logic [`SIZE_DATA-1:0]         bypassDataAlu_o;
        logic                          writebkValidBranch_o;
        logic [ctrlFuWidth-1:0]        ctrlFuBranch_o;
        logic                          bypassValidBranch_o;
        logic [`SIZE_PHYSICAL_LOG-1:0] bypassPhysRegBranch_o;
        logic [`SIZE_DATA-1:0]         bypassDataBranch_o;
        logic                          writebkValidLsu_o;
        logic [ctrlFuWidth-1:0]        ctrlFuLsu_o;
        logic                          bypassValidLsu_o;
        logic [`SIZE_PHYSICAL_LOG-1:0] bypassPhysRegLsu_o;
        logic [`SIZE_DATA-1:0]         bypassDataLsu_o;
        logic                          agenIqFreedValid_o;
        logic [`SIZE_ISSUEQ_LOG-1:0]   agenIqEntry_o;
        logic                          ctrlVerified_o;
        logic                          ctrlMispredict_o;
        logic                          ctrlConditional_o;
        logic [`CHECKPOINTS_LOG-1:0]   ctrlSmtId_o;
        logic [`SIZE_PC-1:0]           ctrlTargetAddr_o;
        logic                          ctrlBrDirection_o;
        logic [`SIZE_CTI_LOG-1:0]      ctrlCtiQueueIndex_o;

        integer seed;
        int     errorCount;
        int     testCount;
        int     cycleCount = 0;

        // Reference model one cycle behind the inputs
        logic [2:0]  modelValid;
        lanePacket_t modelPacket [3];
        branchCtrl_t modelCtrl;
        logic        expSquash;
        logic [2:0]  expWb;
        logic [2:0]  expBypass;

        // Lane outputs indexed as ALU, branch and LSU
        logic [2:0]                    wbOut;
        logic [2:0]                    bypassOut;
        logic [ctrlFuWidth-1:0]        ctrlFuOut [3];
        logic [`SIZE_PHYSICAL_LOG-1:0] physRegOut [3];
        logic [`SIZE_DATA-1:0]         dataOut [3];

        clockGen clocks (
                .clk   (clk),
                .reset (reset)
        );

        writebackStage DUT (.*);

        assign wbOut      = {writebkValidLsu_o, writebkValidBranch_o, writebkValidAlu_o};
        assign bypassOut  = {bypassValidLsu_o, bypassValidBranch_o, bypassValidAlu_o};
        assign ctrlFuOut  = '{ctrlFuAlu_o, ctrlFuBranch_o, ctrlFuLsu_o};
        assign physRegOut = '{bypassPhysRegAlu_o, bypassPhysRegBranch_o, bypassPhysRegLsu_o};
        assign dataOut    = '{bypassDataAlu_o, bypassDataBranch_o, bypassDataLsu_o};

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        modelValid <= '0;
                end
                else
                begin
                        modelValid <= {lsuPacketValid_i, branchPacketValid_i, aluPacketValid_i};
                end
                // Packets kept across idle cycles
                if (aluPacketValid_i)
                        modelPacket[0] <= aluPacket_i;
                if (branchPacketValid_i)
                        modelPacket[1] <= branchPacket_i;
                if (lsuPacketValid_i)
                        modelPacket[2] <= lsuPacket_i;
                if (branchPacketValid_i)
                        modelCtrl <= branchCtrl_i;
        end

        always_comb
        begin
                expSquash = modelValid[1] & modelPacket[1].flags.wb.mispredict;
                for (int i = 0; i < 3; i++)
                begin
                        expWb[i] = modelValid[i]
                                & ~(expSquash & modelPacket[i].branchMask[modelCtrl.smtId]);
                        expBypass[i] = modelValid[i] & modelPacket[i].flags.bypassEnable;
                end
        end

        for (genvar i = 0; i < 3; i++)
        begin : laneChecks
                localparam string laneName = (i == 0) ? "Alu" : (i == 1) ? "Branch" : "Lsu";

                assert property (@(posedge clk) disable iff (reset) wbOut[i] == expWb[i])
                        else valueError($sformatf("writebkValid%s_o", laneName),
                                64'($sampled(expWb[i])), 64'($sampled(wbOut[i])));
                assert property (@(posedge clk) disable iff (reset) bypassOut[i] == expBypass[i])
                        else valueError($sformatf("bypassValid%s_o", laneName),
                                64'($sampled(expBypass[i])), 64'($sampled(bypassOut[i])));
                assert property (@(posedge clk) disable iff (reset) modelValid[i] |->
                                ctrlFuOut[i] == {modelPacket[i].alId, modelPacket[i].flags.wb})
                        else valueError($sformatf("ctrlFu%s_o", laneName),
                                64'($sampled({modelPacket[i].alId, modelPacket[i].flags.wb})),
                                64'($sampled(ctrlFuOut[i])));
                assert property (@(posedge clk) disable iff (reset) modelValid[i] |->
                                physRegOut[i] == modelPacket[i].physReg)
                        else valueError($sformatf("bypassPhysReg%s_o", laneName),
                                64'($sampled(modelPacket[i].physReg)),
                                64'($sampled(physRegOut[i])));
                assert property (@(posedge clk) disable iff (reset) modelValid[i] |->
                                dataOut[i] == modelPacket[i].data)
                        else valueError($sformatf("bypassData%s_o", laneName),
                                64'($sampled(modelPacket[i].data)), 64'($sampled(dataOut[i])));
        end

        assert property (@(posedge clk) disable iff (reset) agenIqFreedValid_o == modelValid[2])
                else valueError("agenIqFreedValid_o", 64'($sampled(modelValid[2])),
                        64'($sampled(agenIqFreedValid_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[2] |->
                        agenIqEntry_o == modelPacket[2].iqEntry)
                else valueError("agenIqEntry_o", 64'($sampled(modelPacket[2].iqEntry)),
                        64'($sampled(agenIqEntry_o)));
        assert property (@(posedge clk) disable iff (reset) ctrlVerified_o == modelValid[1])
                else valueError("ctrlVerified_o", 64'($sampled(modelValid[1])),
                        64'($sampled(ctrlVerified_o)));
        assert property (@(posedge clk) disable iff (reset) ctrlMispredict_o == expSquash)
                else valueError("ctrlMispredict_o", 64'($sampled(expSquash)),
                        64'($sampled(ctrlMispredict_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[1] |->
                        ctrlConditional_o == modelPacket[1].flags.conditional)
                else valueError("ctrlConditional_o",
                        64'($sampled(modelPacket[1].flags.conditional)),
                        64'($sampled(ctrlConditional_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[1] |->
                        ctrlSmtId_o == modelCtrl.smtId)
                else valueError("ctrlSmtId_o", 64'($sampled(modelCtrl.smtId)),
                        64'($sampled(ctrlSmtId_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[1] |->
                        ctrlTargetAddr_o == modelCtrl.targetPc)
                else valueError("ctrlTargetAddr_o", 64'($sampled(modelCtrl.targetPc)),
                        64'($sampled(ctrlTargetAddr_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[1] |->
                        ctrlBrDirection_o == modelCtrl.direction)
                else valueError("ctrlBrDirection_o", 64'($sampled(modelCtrl.direction)),
                        64'($sampled(ctrlBrDirection_o)));
        assert property (@(posedge clk) disable iff (reset) modelValid[1] |->
                        ctrlCtiQueueIndex_o == modelCtrl.ctiIndex)
                else valueError("ctrlCtiQueueIndex_o", 64'($sampled(modelCtrl.ctiIndex)),
                        64'($sampled(ctrlCtiQueueIndex_o)));

        task automatic valueError(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
                $display("error at %0d ns: %s expected %0h, got %0h",
                        $time, name, expected, actual);
                errorCount++;
        endtask

        function automatic logic [31:0] randomWord();
                return $random(seed);
        endfunction

        function automatic lanePacket_t randomPacket();
                logic [63:0] word;
                word = {randomWord(), randomWord()};
                return word[$bits(lanePacket_t)-1:0];
        endfunction

        function automatic branchCtrl_t randomCtrl();
                logic [63:0] word;
                word = {randomWord(), randomWord()};
                return word[$bits(branchCtrl_t)-1:0];
        endfunction

        task automatic nextCycle();
                @(posedge clk);
                #1;
        endtask

        task automatic idleInputs();
                aluPacketValid_i    = 1'b0;
                branchPacketValid_i = 1'b0;
                lsuPacketValid_i    = 1'b0;
                aluPacket_i         = '0;
                branchPacket_i      = '0;
                branchCtrl_i        = '0;
                lsuPacket_i         = '0;
        endtask

        // Random packets on the lanes in laneMask with about one idle cycle in four
        task automatic randomTraffic(input logic [2:0] laneMask, input int cycles);
                logic [31:0] word;
                for (int n = 0; n < cycles; n++)
                begin
                        word                = randomWord();
                        aluPacketValid_i    = laneMask[0] & (word[1:0] != 2'b00);
                        branchPacketValid_i = laneMask[1] & (word[3:2] != 2'b00);
                        lsuPacketValid_i    = laneMask[2] & (word[5:4] != 2'b00);
                        aluPacket_i         = randomPacket();
                        branchPacket_i      = randomPacket();
                        branchCtrl_i        = randomCtrl();
                        lsuPacket_i         = randomPacket();
                        nextCycle();
                end
        endtask

        // Each checkpoint with the mask bit set and clear, then again without mispredict
        task automatic runSquash();
                logic [4:0] n;
                for (int i = 0; i < 32; i++)
                begin
                        n                   = 5'(i);
                        aluPacketValid_i    = 1'b1;
                        branchPacketValid_i = 1'b1;
                        lsuPacketValid_i    = 1'b1;
                        aluPacket_i         = randomPacket();
                        branchPacket_i      = randomPacket();
                        branchCtrl_i        = randomCtrl();
                        lsuPacket_i         = randomPacket();
                        branchPacket_i.flags.wb.mispredict = ~n[4];
                        branchCtrl_i.smtId                 = n[1:0];
                        aluPacket_i.branchMask[n[1:0]]     = n[2];
                        lsuPacket_i.branchMask[n[1:0]]     = ~n[2];
                        nextCycle();
                end
        endtask

        task automatic finishTest(input string name);
                idleInputs();
                repeat (2) nextCycle();
                testCount++;
                $display("test %0d, %s, done with %0d errors so far", testCount, name, errorCount);
        endtask

        always @(posedge clk)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit)
                begin
                        $display("timeout, run still going after %0d cycles", cycleLimit);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        initial
        begin
                seed       = 7;
                errorCount = 0;
                testCount  = 0;
                idleInputs();
                @(negedge reset);

                repeat (3) nextCycle();
                randomTraffic(3'b111, 1);
                idleInputs();
                repeat (3) nextCycle();
                finishTest("reset and idle");

                randomTraffic(3'b001, 20);
                finishTest("ALU writeback and bypass");
                randomTraffic(3'b100, 20);
                finishTest("load/store lane");
                randomTraffic(3'b010, 20);
                finishTest("branch resolution");
                runSquash();
                finishTest("squash");

                $display("%0d tests run, %0d errors", testCount, errorCount);
                if (errorCount == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule
